//--- common/nlc_pkg.sv
`default_nettype none

package nlc_pkg;

	// Channel organisation
	localparam int NUM_CH = 16;
	localparam int CH_W = 4;

	// Sample and fixed-point formats
	localparam int ADC_W = 21;
	localparam int DATA_W = 32;
	localparam int FRAC_BITS = 16;

	// Polynomial evaluation
	localparam int POLY_ORDER = 5;
	localparam int OPS_PER_CH = 6;

	typedef enum logic [0:0] {
		st_idle,
		st_run
	} seq_state_e;

	typedef enum logic [1:0] {
		op_norm,
		op_horner_first,
		op_horner_step
	} nlc_op_e;

	// Coefficients first, so a coefficient's index is its select value
	typedef enum logic [2:0] {
		sel_coeff0,
		sel_coeff1,
		sel_coeff2,
		sel_coeff3,
		sel_coeff4,
		sel_coeff5,
		sel_mean,
		sel_recip
	} param_sel_e;

endpackage

`default_nettype wire

//--- decode/nlc_decode.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_decode
	import nlc_pkg::*;
#(
	parameter int NUM_CH = 16,
	parameter int ADC_W = 21,
	parameter int DATA_W = 32
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [NUM_CH-1:0][ADC_W-1:0] adc_x,
	input logic cfg_we,
	input logic [$clog2(NUM_CH)-1:0] cfg_ch,
	input param_sel_e cfg_sel,
	input logic [DATA_W-1:0] cfg_data,
	output logic busy,
	output logic op_valid,
	output nlc_op_e op,
	output logic [$clog2(NUM_CH)-1:0] op_ch,
	output logic op_last,
	output logic [DATA_W-1:0] opnd_a,
	output logic [DATA_W-1:0] opnd_b,
	output logic [DATA_W-1:0] opnd_c
);

	localparam int CW = $clog2(NUM_CH);
	localparam int STEP_W = $clog2(OPS_PER_CH);

	seq_state_e state;
	logic [CW-1:0] ch_cnt;
	logic [STEP_W-1:0] step_cnt;
	logic [NUM_CH-1:0][ADC_W-1:0] samples;
	logic [2:0] coeff_idx;
	param_sel_e rd_sel;
	logic [2*DATA_W-1:0] bank_data;
	logic [DATA_W-1:0] word_lo;
	logic [DATA_W-1:0] word_hi;
	logic [ADC_W-1:0] sample;
	logic [ADC_W-1:0] mean;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ch_cnt <= '0;
			step_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						ch_cnt <= '0;
						step_cnt <= '0;
					end
				end
				st_run: begin
					if (op_last) begin
						step_cnt <= '0;
						ch_cnt <= ch_cnt + 1'b1;
						if (ch_cnt == CW'(NUM_CH - 1))
							state <= st_idle;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Whole sample array held for the run
	always_ff @(posedge clk) begin
		if (state == st_idle && start)
			samples <= adc_x;
	end

	assign busy = (state == st_run);
	assign op_valid = (state == st_run);
	assign op_ch = ch_cnt;
	assign op_last = (step_cnt == STEP_W'(OPS_PER_CH - 1));

	always_comb begin
		case (step_cnt)
			STEP_W'(0): op = op_norm;
			STEP_W'(1): op = op_horner_first;
			default: op = op_horner_step;
		endcase
	end

	// Step 1 reads c4 (with c5 above it), step 5 reads c0
	assign coeff_idx = 3'(POLY_ORDER) - 3'(step_cnt);
	assign rd_sel = (step_cnt == '0) ? sel_mean : param_sel_e'(coeff_idx);

	nlc_param_bank #(
		.NUM_CH(NUM_CH),
		.DATA_W(DATA_W)
	) u_param_bank (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we && !busy),
		.cfg_ch(cfg_ch),
		.cfg_sel(cfg_sel),
		.cfg_data(cfg_data),
		.rd_ch(ch_cnt),
		.rd_sel(rd_sel),
		.rd_data(bank_data)
	);

	assign word_lo = bank_data[DATA_W-1:0];
	assign word_hi = bank_data[2*DATA_W-1:DATA_W];
	assign sample = samples[ch_cnt];
	assign mean = word_lo[ADC_W-1:0];

	always_comb begin
		opnd_a = '0;
		opnd_b = '0;
		opnd_c = word_lo;
		case (op)
			op_norm: begin
				opnd_a = {{(DATA_W - ADC_W){sample[ADC_W-1]}}, sample};
				opnd_b = {{(DATA_W - ADC_W){mean[ADC_W-1]}}, mean};
				opnd_c = word_hi;
			end
			op_horner_first: opnd_a = word_hi;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- decode/nlc_param_bank.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_param_bank
	import nlc_pkg::*;
#(
	parameter int NUM_CH = 16,
	parameter int DATA_W = 32
) (
	input logic clk,
	input logic rst,
	input logic cfg_we,
	input logic [$clog2(NUM_CH)-1:0] cfg_ch,
	input param_sel_e cfg_sel,
	input logic [DATA_W-1:0] cfg_data,
	input logic [$clog2(NUM_CH)-1:0] rd_ch,
	input param_sel_e rd_sel,
	output logic [2*DATA_W-1:0] rd_data
);

	localparam int NUM_SEL = 8;

	logic [DATA_W-1:0] mem [NUM_CH][NUM_SEL];
	param_sel_e rd_sel_hi;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < NUM_CH; c++) begin
				for (int s = 0; s < NUM_SEL; s++) begin
					mem[c][s] <= '0;
				end
			end
		end else if (cfg_we) begin
			mem[cfg_ch][cfg_sel] <= cfg_data;
		end
	end

	// Two adjacent entries per read.
	// mean/recip and coeff4/coeff5 come out as pairs in one cycle
	assign rd_sel_hi = param_sel_e'(rd_sel + 3'd1);

	assign rd_data = {mem[rd_ch][rd_sel_hi], mem[rd_ch][rd_sel]};

endmodule

`default_nettype wire

//--- dv/nlc_cases.txt
// mean recip c5 c4 c3 c2 c1 c0 sample_base sample_step
// then the expected results, channels 0-7 on one line and 8-15 on the next
00000000 00010000 00000000 00000000 00000000 00000000 00010000 00000000 00000000 00010000
0 1 2 3 4 5 6 7
8 9 a b c d e f
0001f000 00000000 00000000 00000000 00000000 00000000 00000000 fff80000 000abcde 00001111
1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8
1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8 1ffff8
00000100 00010000 00000000 00000000 00000000 00000000 00020000 00030000 00000100 00010000
3 5 7 9 b d f 11
13 15 17 19 1b 1d 1f 21
00000000 00010000 00000000 00000000 00000000 00010000 00000000 00000000 fff80000 00010000
40 31 24 19 10 9 4 1
0 1 4 9 10 19 24 31
00000000 00010000 00000000 00000000 00000000 00000000 00000000 7fffffff 00000000 00012345
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
00000000 00010000 00000000 00000000 00000000 00000000 7fff0000 7fff0000 00010000 00000000
1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe
1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe 1ffffe
00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000000 00054321 00000777
1f8000 1f8000 1f8000 1f8000 1f8000 1f8000 1f8000 1f8000
1f8000 1f8000 1f8000 1f8000 1f8000 1f8000 1f8000 1f8000

//--- dv/nlc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_properties
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done
);

	localparam int BUSY_CYCLES = NUM_CH * OPS_PER_CH;
	localparam int DONE_DELAY = BUSY_CYCLES + 2;

	a_done_not_busy: assert property (
		@(posedge clk) disable iff (rst)
		done |-> !busy
	) else $error("done is high while busy is high");

	// Accepted start to done
	a_done_delay: assert property (
		@(posedge clk) disable iff (rst)
		(start && !busy) |-> ##DONE_DELAY done
	) else $error("done did not follow the accepted start in time");

	a_busy_length: assert property (
		@(posedge clk) disable iff (rst)
		(start && !busy) |=> busy [*BUSY_CYCLES] ##1 !busy
	) else $error("busy did not stay high for one full run");

endmodule

bind nlc_top nlc_properties u_properties (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.done(done)
);

`default_nettype wire

//--- dv/nlc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_tb
	import nlc_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_CASES = 7;
	localparam int ROW_WORDS = 26;
	localparam int NUM_SEL = 8;
	localparam int DONE_LATENCY = NUM_CH * OPS_PER_CH + 2;
	localparam int DONE_LIMIT = 2 * DONE_LATENCY;
	localparam int RUN_CYCLES = 2 * (NUM_CH * NUM_SEL + DONE_LATENCY + NUM_CH);
	localparam int NUM_RUNS = NUM_CASES + 3;
	localparam int WATCHDOG_NS = (2 * RESET_CYCLES + NUM_RUNS * RUN_CYCLES) * CLK_PERIOD;
	localparam int SAT_HI = 2 ** (ADC_W - 1) - 1;
	localparam int SAT_LO = -(2 ** (ADC_W - 1));
	localparam logic [31:0] SEED = 32'h8bb3_5d7b;

	logic clk;
	logic rst;
	logic start;
	logic [NUM_CH-1:0][ADC_W-1:0] adc_x;
	logic cfg_we;
	logic [CH_W-1:0] cfg_ch;
	param_sel_e cfg_sel;
	logic [DATA_W-1:0] cfg_data;
	logic [CH_W-1:0] rd_ch;
	logic busy;
	logic done;
	logic [ADC_W-1:0] rd_data;

	logic [31:0] case_mem [NUM_CASES*ROW_WORDS];
	logic [DATA_W-1:0] prm [NUM_CH][NUM_SEL];
	logic [ADC_W-1:0] smp [NUM_CH];
	logic [ADC_W-1:0] exp_res [NUM_CH];

	nlc_top u_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.adc_x(adc_x),
		.cfg_we(cfg_we),
		.cfg_ch(cfg_ch),
		.cfg_sel(cfg_sel),
		.cfg_data(cfg_data),
		.rd_ch(rd_ch),
		.busy(busy),
		.done(done),
		.rd_data(rd_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			fail_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, want));
		end
	endtask

	// Q16 multiply with full product, shift and truncation
	function automatic logic [DATA_W-1:0] qmul(input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] wa;
		logic signed [2*DATA_W-1:0] wb;
		logic signed [2*DATA_W-1:0] p;
		wa = $signed(a);
		wb = $signed(b);
		p = (wa * wb) >>> FRAC_BITS;
		return p[DATA_W-1:0];
	endfunction

	function automatic logic [ADC_W-1:0] model_result(input int ch);
		logic signed [DATA_W-1:0] s_ext;
		logic signed [DATA_W-1:0] m_ext;
		logic [DATA_W-1:0] x;
		logic [DATA_W-1:0] acc;
		logic signed [DATA_W-1:0] sh;
		s_ext = $signed(smp[ch]);
		m_ext = $signed(prm[ch][sel_mean][ADC_W-1:0]);
		x = qmul(s_ext - m_ext, prm[ch][sel_recip]);
		acc = qmul(prm[ch][5], x) + prm[ch][4];
		for (int i = 3; i >= 0; i--)
			acc = qmul(acc, x) + prm[ch][i];
		sh = $signed(acc) >>> FRAC_BITS;
		if (sh > SAT_HI)
			model_result = ADC_W'(SAT_HI);
		else if (sh < SAT_LO)
			model_result = ADC_W'(SAT_LO);
		else
			model_result = sh[ADC_W-1:0];
	endfunction

	// Same parameters on every channel and samples base + k * step
	task automatic set_case(input int r);
		int b;
		b = r * ROW_WORDS;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			prm[ch][sel_mean] = case_mem[b];
			prm[ch][sel_recip] = case_mem[b+1];
			for (int i = 0; i <= POLY_ORDER; i++)
				prm[ch][POLY_ORDER-i] = case_mem[b+2+i];
			smp[ch] = ADC_W'(case_mem[b+8] + ch * case_mem[b+9]);
			exp_res[ch] = case_mem[b+10+ch][ADC_W-1:0];
			check_value($sformatf("cases row %0d expected[%0d]", r, ch),
				32'(model_result(ch)), 32'(exp_res[ch]));
		end
	endtask

	task automatic set_random();
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			prm[ch][sel_mean] = $urandom;
			prm[ch][sel_recip] = $urandom & 32'h0003_ffff;
			for (int i = 0; i <= POLY_ORDER; i++) begin
				r = $urandom;
				prm[ch][i] = {{(DATA_W - 18){r[17]}}, r[17:0]};
			end
			smp[ch] = ADC_W'($urandom);
			exp_res[ch] = model_result(ch);
		end
	endtask

	task automatic load_params();
		for (int ch = 0; ch < NUM_CH; ch++) begin
			for (int s = 0; s < NUM_SEL; s++) begin
				@(posedge clk);
				#1;
				cfg_we = 1'b1;
				cfg_ch = CH_W'(ch);
				cfg_sel = param_sel_e'(s);
				cfg_data = prm[ch][s];
			end
		end
		@(posedge clk);
		#1 cfg_we = 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#1;
		check_value("busy before start", 32'(busy), 32'd0);
		for (int k = 0; k < NUM_CH; k++)
			adc_x[k] = smp[k];
		start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
	endtask

	// Cycle count is the edge at which done is sampled high
	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > DONE_LIMIT)
				fail_run("done did not arrive after start");
		end while (!done);
		check_value("busy at done", 32'(busy), 32'd0);
		@(negedge clk);
		check_value("done after its pulse", 32'(done), 32'd0);
	endtask

	task automatic check_results();
		for (int ch = 0; ch < NUM_CH; ch++) begin
			@(posedge clk);
			#1 rd_ch = CH_W'(ch);
			#1 check_value($sformatf("rd_data[%0d]", ch), 32'(rd_data), 32'(exp_res[ch]));
		end
	endtask

	task automatic run_and_check();
		int cycles;
		pulse_start();
		wait_done(cycles);
		check_value("done latency", cycles, DONE_LATENCY);
		check_results();
	endtask

	// Second start and parameter writes while the run is busy
	task automatic run_with_disturbance();
		int cycles;
		pulse_start();
		fork
			wait_done(cycles);
			begin
				repeat (4) @(posedge clk);
				for (int i = 0; i < 64; i++) begin
					@(posedge clk);
					#1;
					check_value("busy during run", 32'(busy), 32'd1);
					cfg_we = 1'b1;
					cfg_ch = CH_W'(i % NUM_CH);
					cfg_sel = param_sel_e'(i / 8);
					cfg_data = 32'h5a5a_0000 + i;
					start = (i == 30);
				end
				@(posedge clk);
				#1;
				cfg_we = 1'b0;
				start = 1'b0;
			end
		join
		check_value("done latency with start while busy", cycles, DONE_LATENCY);
		repeat (4) begin
			@(posedge clk);
			#1 check_value("busy after done", 32'(busy), 32'd0);
		end
		check_results();
	endtask

	task automatic check_reset_state();
		check_value("busy after reset", 32'(busy), 32'd0);
		check_value("done after reset", 32'(done), 32'd0);
		for (int ch = 0; ch < NUM_CH; ch++)
			exp_res[ch] = '0;
		check_results();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		adc_x = '0;
		cfg_we = 1'b0;
		cfg_ch = '0;
		cfg_sel = sel_coeff0;
		cfg_data = '0;
		rd_ch = '0;
		void'($urandom(SEED));
		$readmemh("dv/nlc_cases.txt", case_mem);
		for (int i = 0; i < NUM_CASES * ROW_WORDS; i++) begin
			if ($isunknown(case_mem[i]))
				fail_run("the cases file dv/nlc_cases.txt is missing or too short");
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
		check_reset_state();

		for (int r = 0; r < NUM_CASES; r++) begin
			set_case(r);
			load_params();
			run_and_check();
		end

		set_random();
		load_params();
		run_and_check();
		run_with_disturbance();
		run_and_check();

		@(posedge clk);
		#1 rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
		check_reset_state();

		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog timeout, the test did not finish in time");
	end

endmodule

`default_nettype wire

//--- flist.f
common/nlc_pkg.sv
decode/nlc_param_bank.sv
decode/nlc_decode.sv
verilog/nlc_execute.sv
verilog/nlc_result.sv
verilog/nlc_top.sv
dv/nlc_properties.sv
dv/nlc_tb.sv

//--- verilog/nlc_execute.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_execute
	import nlc_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int FRAC_BITS = 16
) (
	input logic clk,
	input logic rst,
	input logic op_valid,
	input nlc_op_e op,
	input logic [CH_W-1:0] op_ch,
	input logic op_last,
	input logic [DATA_W-1:0] opnd_a,
	input logic [DATA_W-1:0] opnd_b,
	input logic [DATA_W-1:0] opnd_c,
	output logic acc_valid,
	output logic [CH_W-1:0] acc_ch,
	output logic [DATA_W-1:0] acc
);

	logic signed [DATA_W-1:0] mul_a;
	logic signed [DATA_W-1:0] mul_b;
	logic signed [2*DATA_W-1:0] prod;
	logic signed [2*DATA_W-1:0] prod_sh;
	logic [DATA_W-1:0] prod_tr;
	logic [DATA_W-1:0] x_norm;

	// One multiplier shared by all opcodes
	always_comb begin
		case (op)
			op_norm: begin
				mul_a = opnd_a - opnd_b;
				mul_b = opnd_c;
			end
			op_horner_first: begin
				mul_a = opnd_a;
				mul_b = x_norm;
			end
			default: begin
				mul_a = acc;
				mul_b = x_norm;
			end
		endcase
	end

	assign prod = mul_a * mul_b;
	assign prod_sh = prod >>> FRAC_BITS;
	assign prod_tr = prod_sh[DATA_W-1:0];

	// Norm only touches x_norm, so acc still holds the previous
	// channel's result while result samples it
	always_ff @(posedge clk) begin
		if (op_valid) begin
			if (op == op_norm)
				x_norm <= prod_tr;
			else
				acc <= prod_tr + opnd_c;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			acc_valid <= 1'b0;
		else
			acc_valid <= op_valid && op_last;
	end

	always_ff @(posedge clk) begin
		if (op_valid && op_last)
			acc_ch <= op_ch;
	end

endmodule

`default_nettype wire

//--- verilog/nlc_result.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_result #(
	parameter int NUM_CH = 16,
	parameter int ADC_W = 21,
	parameter int DATA_W = 32,
	parameter int FRAC_BITS = 16
) (
	input logic clk,
	input logic rst,
	input logic acc_valid,
	input logic [$clog2(NUM_CH)-1:0] acc_ch,
	input logic [DATA_W-1:0] acc,
	input logic [$clog2(NUM_CH)-1:0] rd_ch,
	output logic [ADC_W-1:0] rd_data,
	output logic done
);

	localparam int CW = $clog2(NUM_CH);
	localparam logic signed [DATA_W-1:0] SAT_MAX = DATA_W'((1 << (ADC_W - 1)) - 1);
	localparam logic signed [DATA_W-1:0] SAT_MIN = -SAT_MAX - 1;

	logic signed [DATA_W-1:0] acc_sh;
	logic [ADC_W-1:0] sat;
	logic [ADC_W-1:0] res [NUM_CH];

	assign acc_sh = signed'(acc) >>> FRAC_BITS;

	// Clamp to the signed sample range
	always_comb begin
		if (acc_sh > SAT_MAX)
			sat = SAT_MAX[ADC_W-1:0];
		else if (acc_sh < SAT_MIN)
			sat = SAT_MIN[ADC_W-1:0];
		else
			sat = acc_sh[ADC_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < NUM_CH; c++)
				res[c] <= '0;
			done <= 1'b0;
		end else begin
			done <= acc_valid && (acc_ch == CW'(NUM_CH - 1));
			if (acc_valid)
				res[acc_ch] <= sat;
		end
	end

	assign rd_data = res[rd_ch];

endmodule

`default_nettype wire

//--- verilog/nlc_top.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_top
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [NUM_CH-1:0][ADC_W-1:0] adc_x,
	input logic cfg_we,
	input logic [CH_W-1:0] cfg_ch,
	input param_sel_e cfg_sel,
	input logic [DATA_W-1:0] cfg_data,
	input logic [CH_W-1:0] rd_ch,
	output logic busy,
	output logic done,
	output logic [ADC_W-1:0] rd_data
);

	logic op_valid;
	nlc_op_e op;
	logic [CH_W-1:0] op_ch;
	logic op_last;
	logic [DATA_W-1:0] opnd_a;
	logic [DATA_W-1:0] opnd_b;
	logic [DATA_W-1:0] opnd_c;
	logic acc_valid;
	logic [CH_W-1:0] acc_ch;
	logic [DATA_W-1:0] acc;

	nlc_decode #(
		.NUM_CH(NUM_CH),
		.ADC_W(ADC_W),
		.DATA_W(DATA_W)
	) u_decode (
		.clk(clk),
		.rst(rst),
		.start(start),
		.adc_x(adc_x),
		.cfg_we(cfg_we),
		.cfg_ch(cfg_ch),
		.cfg_sel(cfg_sel),
		.cfg_data(cfg_data),
		.busy(busy),
		.op_valid(op_valid),
		.op(op),
		.op_ch(op_ch),
		.op_last(op_last),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.opnd_c(opnd_c)
	);

	nlc_execute #(
		.DATA_W(DATA_W),
		.FRAC_BITS(FRAC_BITS)
	) u_execute (
		.clk(clk),
		.rst(rst),
		.op_valid(op_valid),
		.op(op),
		.op_ch(op_ch),
		.op_last(op_last),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.opnd_c(opnd_c),
		.acc_valid(acc_valid),
		.acc_ch(acc_ch),
		.acc(acc)
	);

	nlc_result #(
		.NUM_CH(NUM_CH),
		.ADC_W(ADC_W),
		.DATA_W(DATA_W),
		.FRAC_BITS(FRAC_BITS)
	) u_result (
		.clk(clk),
		.rst(rst),
		.acc_valid(acc_valid),
		.acc_ch(acc_ch),
		.acc(acc),
		.rd_ch(rd_ch),
		.rd_data(rd_data),
		.done(done)
	);

endmodule

`default_nettype wire
